//--- fixed_isqrt/isqrt_lut.mem
// Entry i is 1/sqrt(1 + i/32) in Q1.15, rounded down, i from 0 to 31
8000
7E0B
7C2D
7A64
78AD
7709
7575
73F1
727C
7114
6FBA
6E6B
6D28
6BF0
6AC2
699E
6882
6770
6666
6564
6469
6375
6288
61A2
60C2
5FE8
5F13
5E44
5D7A
5CB5
5BF5
5B39

//--- sources.f
common/isqrt_pkg.sv
rtl/skid_buffer.sv
fixed_isqrt/fixed_range_reduction.sv
fixed_isqrt/fixed_isqrt_lut.sv
fixed_isqrt/fixed_nr_stage.sv
fixed_isqrt/fixed_range_augmentation.sv
fixed_isqrt/fixed_isqrt.sv
test/isqrt_checker.sv
test/tb_fixed_isqrt.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -Wno-fatal -f sources.f --top-module tb_fixed_isqrt \
    && ./obj_dir/Vtb_fixed_isqrt | tee sim.log \
    || { echo "Build or simulation did not complete"; exit 1; }

grep -q "Some tests failed" sim.log && exit 1 || exit 0

//--- test/tb_fixed_isqrt.sv
`timescale 1ns/1ps

module tb_fixed_isqrt
    import isqrt_pkg::*;
();

    localparam int N_TABLE    = 20;
    localparam int N_RANDOM   = 200;
    localparam int MAX_CYCLES = 20 * (N_TABLE + N_RANDOM) + 100;

    // Input word and number of cycles to hold out_ready low from it on
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [7:0]            stall;
    } stim_t;

    logic                  clk = 1'b0;
    logic                  arst_n;
    logic [DATA_WIDTH-1:0] in_data;
    logic                  in_valid;
    logic                  in_ready;
    logic [DATA_WIDTH-1:0] out_data;
    logic                  out_valid;
    logic                  out_ready;
    int                    value_errors;
    int                    flow_errors;
    int                    pending;
    int                    cycle_count = 0;
    int                    stall_left;
    logic [31:0]           lcg_state;

    stim_t stim_table [N_TABLE] = '{
        '{16'h0000, 8'd0}, '{16'h0080, 8'd0}, '{16'h0200, 8'd0}, '{16'h0800, 8'd0},
        '{16'h0020, 8'd0}, '{16'h0100, 8'd0}, '{16'h0040, 8'd0}, '{16'h0001, 8'd0},
        '{16'hFFFF, 8'd0}, '{16'h0002, 8'd0}, '{16'h2000, 8'd0}, '{16'h0123, 8'd10},
        '{16'h4000, 8'd0}, '{16'h00C0, 8'd0}, '{16'h1234, 8'd0}, '{16'h0555, 8'd0},
        '{16'h7FFF, 8'd0}, '{16'h8000, 8'd0}, '{16'h00FF, 8'd0}, '{16'h0300, 8'd0}
    };

    always #50 clk = ~clk;

    fixed_isqrt i_dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    isqrt_checker i_checker (
        .clk          (clk),
        .arst_n       (arst_n),
        .in_data      (in_data),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .out_data     (out_data),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .value_errors (value_errors),
        .flow_errors  (flow_errors),
        .pending      (pending)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Sets out_ready for the coming rising edge
    task automatic drive_ready(input logic random_ready);
        if (random_ready) begin
            lcg_state = lcg_next(lcg_state);
            out_ready = (lcg_state[31:30] != 2'b00);
        end else begin
            out_ready = (stall_left == 0);
            if (stall_left > 0) begin
                stall_left--;
            end
        end
    endtask

    // in_ready only moves on a rising edge, so it is read on the falling one
    task automatic send_word(input logic [DATA_WIDTH-1:0] data, input logic random_ready);
        logic taken;
        in_data  = data;
        in_valid = 1'b1;
        taken    = 1'b0;
        while (!taken) begin
            drive_ready(random_ready);
            taken = in_ready;
            @(negedge clk);
        end
        in_valid = 1'b0;
    endtask

    task automatic idle_cycles(input int count, input logic random_ready);
        repeat (count) begin
            drive_ready(random_ready);
            @(negedge clk);
        end
    endtask

    initial begin
        logic [DATA_WIDTH-1:0] data;
        int                    gap;
        arst_n     = 1'b0;
        in_data    = '0;
        in_valid   = 1'b0;
        out_ready  = 1'b1;
        stall_left = 0;
        lcg_state  = 32'hb9cc_7043;
        repeat (4) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);

        for (int i = 0; i < N_TABLE; i++) begin
            if (stim_table[i].stall != 0) begin
                stall_left = int'(stim_table[i].stall);
            end
            send_word(stim_table[i].data, 1'b0);
        end

        for (int i = 0; i < N_RANDOM; i++) begin
            lcg_state = lcg_next(lcg_state);
            gap       = int'(lcg_state[31:30]);
            lcg_state = lcg_next(lcg_state);
            data      = lcg_state[31:16];
            idle_cycles(gap, 1'b1);
            send_word(data, 1'b1);
        end

        // Drain whatever is still in the pipeline
        out_ready = 1'b1;
        while (pending != 0) begin
            @(negedge clk);
        end

        $display("Value errors: %0d, handshake errors: %0d", value_errors, flow_errors);
        if (value_errors == 0 && flow_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    always @(negedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles with %0d results still missing",
                     cycle_count, pending);
            $display("Value errors: %0d, handshake errors: %0d", value_errors, flow_errors);
            $display("Some tests failed");
            $finish;
        end
    end

endmodule

//--- test/isqrt_checker.sv
`timescale 1ns/1ps

module isqrt_checker
    import isqrt_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [DATA_WIDTH-1:0] in_data,
    input  logic                  in_valid,
    input  logic                  in_ready,
    input  logic [DATA_WIDTH-1:0] out_data,
    input  logic                  out_valid,
    input  logic                  out_ready,
    output int                    value_errors,
    output int                    flow_errors,
    output int                    pending
);

    logic [DATA_WIDTH-1:0] input_q [$];
    longint                accept_q [$];
    longint                cycle = 0;
    int                    value_count = 0;
    int                    flow_count = 0;
    int                    in_flight = 0;
    int                    ready_streak = 0;
    int                    stall_streak = 0;

    assign value_errors = value_count;
    assign flow_errors  = flow_count;
    assign pending      = in_flight;

    // Ideal 1/sqrt in Q9.7 units
    function automatic real ideal_result(input logic [DATA_WIDTH-1:0] x);
        real scale;
        scale = real'(1 << FRAC_WIDTH);
        return scale / $sqrt(real'(x) / scale);
    endfunction

    task automatic check_result(input logic [DATA_WIDTH-1:0] x, input logic [DATA_WIDTH-1:0] y);
        real                   ideal;
        real                   lower;
        logic [DATA_WIDTH-1:0] expected;
        logic                  ok;
        if (x == '0) begin
            expected = MAX_VALUE;
            ok       = (y == expected);
        end else begin
            ideal    = ideal_result(x);
            expected = DATA_WIDTH'($rtoi($floor(ideal)));
            lower    = ideal - 2.0 - 0.01 * ideal;
            if (ideal == $floor(ideal)) begin
                // Powers of four are exact
                ok = (y == expected);
            end else begin
                ok = (real'(y) <= ideal) && (real'(y) >= lower);
            end
        end
        if (!ok) begin
            $display("Error: out_data input %h expected %h actual %h", x, expected, y);
            value_count++;
        end
    endtask

    always @(posedge clk) begin
        logic [DATA_WIDTH-1:0] x;
        longint                latency;
        cycle++;
        if (!arst_n) begin
            if (out_valid || !in_ready) begin
                $display("DUT handshake outputs are not idle during reset");
                flow_count++;
            end
            // Empty pipeline counts as fully drained
            ready_streak = 8;
            stall_streak = 0;
        end else begin
            ready_streak = out_ready ? ready_streak + 1 : 0;
            stall_streak = out_ready ? 0 : stall_streak + 1;

            // All skid slots are empty after a long run of out_ready
            if (!in_ready && ready_streak >= 8) begin
                $display("in_ready low although out_ready has been high for %0d cycles",
                         ready_streak);
                flow_count++;
            end

            // After a long stall in_ready may only be low with all slots full
            if (!in_ready && stall_streak >= 10 && in_flight != 8) begin
                $display("in_ready low with %0d items in flight instead of 8", in_flight);
                flow_count++;
            end

            if (out_valid && out_ready) begin
                if (input_q.size() == 0) begin
                    $display("Result came out with no accepted input waiting for it");
                    flow_count++;
                end else begin
                    x       = input_q.pop_front();
                    latency = cycle - accept_q.pop_front();
                    check_result(x, out_data);
                    if (ready_streak >= latency + 8 && latency != 4) begin
                        $display("Result for input %h took %0d cycles instead of 4",
                                 x, latency);
                        flow_count++;
                    end
                end
            end

            if (in_valid && in_ready) begin
                input_q.push_back(in_data);
                accept_q.push_back(cycle);
            end

            in_flight = input_q.size();
            if (in_flight > 8) begin
                $display("More than eight items in flight");
                flow_count++;
            end
        end
    end

endmodule

//--- fixed_isqrt/fixed_isqrt.sv
`timescale 1ns/1ps

module fixed_isqrt
    import isqrt_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [DATA_WIDTH-1:0] in_data,
    input  logic                  in_valid,
    output logic                  in_ready,
    output logic [DATA_WIDTH-1:0] out_data,
    output logic                  out_valid,
    input  logic                  out_ready
);

    reduce_stage_t         reduce_in;
    reduce_stage_t         reduce_out;
    lut_stage_t            lut_in;
    lut_stage_t            lut_out;
    nr_stage_t             nr_in;
    nr_stage_t             nr_out;
    logic [DATA_WIDTH-1:0] result;

    logic pipe_1_valid;
    logic pipe_1_ready;
    logic pipe_2_valid;
    logic pipe_2_ready;
    logic pipe_3_valid;
    logic pipe_3_ready;

    // Stage 1, normalize into [1, 2)
    fixed_range_reduction i_range_reduction (
        .data  (in_data),
        .stage (reduce_in)
    );

    skid_buffer #(.DATA_WIDTH($bits(reduce_stage_t))) pipe_reg_0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .data_in   (reduce_in),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .data_out  (reduce_out),
        .out_valid (pipe_1_valid),
        .out_ready (pipe_1_ready)
    );

    // Stage 2, first estimate from the table
    assign lut_in.reduce = reduce_out;

    fixed_isqrt_lut i_isqrt_lut (
        .mantissa (reduce_out.mantissa),
        .estimate (lut_in.estimate)
    );

    skid_buffer #(.DATA_WIDTH($bits(lut_stage_t))) pipe_reg_1 (
        .clk       (clk),
        .arst_n    (arst_n),
        .data_in   (lut_in),
        .in_valid  (pipe_1_valid),
        .in_ready  (pipe_1_ready),
        .data_out  (lut_out),
        .out_valid (pipe_2_valid),
        .out_ready (pipe_2_ready)
    );

    // Stage 3, one Newton-Raphson step
    fixed_nr_stage i_nr_stage (
        .stage   (lut_out),
        .refined (nr_in)
    );

    skid_buffer #(.DATA_WIDTH($bits(nr_stage_t))) pipe_reg_2 (
        .clk       (clk),
        .arst_n    (arst_n),
        .data_in   (nr_in),
        .in_valid  (pipe_2_valid),
        .in_ready  (pipe_2_ready),
        .data_out  (nr_out),
        .out_valid (pipe_3_valid),
        .out_ready (pipe_3_ready)
    );

    // Stage 4, undo the normalization and saturate
    fixed_range_augmentation i_range_augmentation (
        .stage  (nr_out),
        .result (result)
    );

    skid_buffer #(.DATA_WIDTH(DATA_WIDTH)) output_reg (
        .clk       (clk),
        .arst_n    (arst_n),
        .data_in   (result),
        .in_valid  (pipe_3_valid),
        .in_ready  (pipe_3_ready),
        .data_out  (out_data),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

endmodule

//--- fixed_isqrt/fixed_range_augmentation.sv
`timescale 1ns/1ps

module fixed_range_augmentation
    import isqrt_pkg::*;
(
    input  nr_stage_t             stage,
    output logic [DATA_WIDTH-1:0] result
);

    logic signed [MSB_WIDTH+1:0]       exponent;
    logic signed [MSB_WIDTH+1:0]       half_exp;
    logic [MSB_WIDTH-1:0]              shift_amount;
    logic [2*MANT_WIDTH-1:0]           y_odd;
    logic [2*MANT_WIDTH-1:0]           y_q2_30;
    logic [2*MANT_WIDTH+MSB_WIDTH-1:0] y_wide;
    logic [2*MANT_WIDTH+MSB_WIDTH-1:0] y_shifted;
    logic [2*MANT_WIDTH+MSB_WIDTH-1:0] y_fixed;

    // Input is m * 2^exponent, exponent ranges from -7 to 8
    assign exponent = (MSB_WIDTH+2)'(int'(stage.msb_index) - FRAC_WIDTH);
    // Floor of exponent/2, odd part handled by the 1/sqrt(2) factor
    assign half_exp = exponent >>> 1;

    assign shift_amount = half_exp[MSB_WIDTH+1] ? MSB_WIDTH'(-half_exp)
                                                : MSB_WIDTH'(half_exp);

    assign y_odd   = stage.y * INV_SQRT2_Q1_15;
    assign y_q2_30 = exponent[0] ? y_odd : (2*MANT_WIDTH)'(stage.y) << (MANT_WIDTH - 1);
    assign y_wide  = (2*MANT_WIDTH+MSB_WIDTH)'(y_q2_30);

    // Small inputs give large results, so negative exponents shift left
    assign y_shifted = half_exp[MSB_WIDTH+1] ? y_wide << shift_amount
                                             : y_wide >> shift_amount;

    // Q2.30 down to Q9.7, truncating
    assign y_fixed = y_shifted >> (2*MANT_WIDTH - 2 - FRAC_WIDTH);

    always_comb begin
        if (stage.special == CASE_ZERO || y_fixed > MAX_VALUE) begin
            result = MAX_VALUE;
        end else begin
            result = y_fixed[DATA_WIDTH-1:0];
        end
    end

endmodule

//--- fixed_isqrt/fixed_nr_stage.sv
`timescale 1ns/1ps

module fixed_nr_stage
    import isqrt_pkg::*;
(
    input  lut_stage_t stage,
    output nr_stage_t  refined
);

    logic [MANT_WIDTH-1:0]   y;
    logic [MANT_WIDTH-1:0]   m;
    logic [2*MANT_WIDTH-1:0] y_sq;
    logic [3*MANT_WIDTH-1:0] m_y_sq;
    logic [3*MANT_WIDTH-1:0] correction;
    logic [4*MANT_WIDTH-1:0] y_next_full;
    logic [MANT_WIDTH-1:0]   y_next;

    assign y = stage.estimate;
    assign m = stage.reduce.mantissa;

    // Q2.30
    assign y_sq = y * y;
    // Q3.45
    assign m_y_sq = m * y_sq;

    // 3.0 in Q3.45 minus m*y^2
    assign correction = ((3*MANT_WIDTH)'(3) << (3*MANT_WIDTH - 3)) - m_y_sq;

    // Q4.60 product, halve and truncate back to Q1.15
    assign y_next_full = y * correction;
    assign y_next      = y_next_full[3*MANT_WIDTH-2 +: MANT_WIDTH];

    always_comb begin
        refined.msb_index = stage.reduce.msb_index;
        refined.special   = stage.reduce.special;
        if (stage.reduce.special == CASE_ONE) begin
            refined.y = ONE_Q1_15;
        end else begin
            refined.y = y_next;
        end
    end

endmodule

//--- fixed_isqrt/fixed_isqrt_lut.sv
`timescale 1ns/1ps

module fixed_isqrt_lut
    import isqrt_pkg::*;
(
    input  logic [MANT_WIDTH-1:0] mantissa,
    output logic [MANT_WIDTH-1:0] estimate
);

    logic [LUT_POW-1:0]    address;
    logic [MANT_WIDTH-1:0] rom [LUT_DEPTH];

    // Entry i holds 1/sqrt(1 + i/32) in Q1.15
    initial begin
        $readmemh("fixed_isqrt/isqrt_lut.mem", rom);
    end

    // Bit 15 is the leading one, the five bits below it select the entry
    assign address = mantissa[MANT_WIDTH-2 -: LUT_POW];

    // Asynchronous read, the stage adds no cycle
    assign estimate = rom[address];

endmodule

//--- fixed_isqrt/fixed_range_reduction.sv
`timescale 1ns/1ps

module fixed_range_reduction
    import isqrt_pkg::*;
(
    input  logic [DATA_WIDTH-1:0] data,
    output reduce_stage_t         stage
);

    logic [MSB_WIDTH-1:0]  msb_index;
    logic [MSB_WIDTH-1:0]  shift_amount;
    logic [MANT_WIDTH-1:0] mantissa;

    // Leading one, the highest set bit wins
    always_comb begin
        msb_index = '0;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            if (data[i]) begin
                msb_index = MSB_WIDTH'(i);
            end
        end
    end

    // Move the leading one up to bit 15
    assign shift_amount = MSB_WIDTH'(MANT_WIDTH - 1) - msb_index;
    assign mantissa     = MANT_WIDTH'(data) << shift_amount;

    always_comb begin
        stage.mantissa  = mantissa;
        stage.msb_index = msb_index;
        if (data == '0) begin
            stage.special = CASE_ZERO;
        end else if (mantissa == ONE_Q1_15) begin
            // Power of two, table and NR step are bypassed
            stage.special = CASE_ONE;
        end else begin
            stage.special = CASE_NORMAL;
        end
    end

endmodule

//--- rtl/skid_buffer.sv
`timescale 1ns/1ps

module skid_buffer #(
    parameter int DATA_WIDTH = 16
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [DATA_WIDTH-1:0] data_in,
    input  logic                  in_valid,
    output logic                  in_ready,
    output logic [DATA_WIDTH-1:0] data_out,
    output logic                  out_valid,
    input  logic                  out_ready
);

    logic [DATA_WIDTH-1:0] skid_data;
    logic                  skid_valid;
    logic                  in_fire;
    logic                  out_stall;

    assign in_fire   = in_valid && in_ready;
    assign out_stall = out_valid && !out_ready;

    // Ready comes straight from a flop, no path from out_ready
    assign in_ready = !skid_valid;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else begin
            if (!out_stall) begin
                // Skid slot drains first, keeps order
                out_valid  <= skid_valid || in_fire;
                skid_valid <= 1'b0;
            end else if (in_fire) begin
                skid_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!out_stall) begin
            data_out <= skid_valid ? skid_data : data_in;
        end
        // Catch the word that arrives while the output is held
        if (out_stall && in_fire) begin
            skid_data <= data_in;
        end
    end

endmodule

//--- common/isqrt_pkg.sv
package isqrt_pkg;

    // Input and output words are unsigned Q9.7
    localparam int DATA_WIDTH = 16;
    localparam int FRAC_WIDTH = 7;

    // Normalized mantissa is Q1.15 in [1, 2)
    localparam int MANT_WIDTH = 16;
    localparam int MSB_WIDTH  = 4;

    // Initial estimate table
    localparam int LUT_POW   = 5;
    localparam int LUT_DEPTH = 32;

    localparam logic [DATA_WIDTH-1:0] MAX_VALUE = 16'hFFFF;

    localparam logic [MANT_WIDTH-1:0] ONE_Q1_15 = 16'h8000;
    // 0.70710678 * 2^15, rounded down
    localparam logic [MANT_WIDTH-1:0] INV_SQRT2_Q1_15 = 16'h5A82;

    typedef enum logic [1:0] {
        CASE_NORMAL,
        CASE_ZERO,
        CASE_ONE
    } isqrt_case_e;

    // After range reduction
    typedef struct packed {
        logic [MANT_WIDTH-1:0] mantissa;
        logic [MSB_WIDTH-1:0]  msb_index;
        isqrt_case_e           special;
    } reduce_stage_t;

    // After the table lookup
    typedef struct packed {
        reduce_stage_t         reduce;
        logic [MANT_WIDTH-1:0] estimate;
    } lut_stage_t;

    // After the Newton-Raphson step, mantissa no longer needed
    typedef struct packed {
        logic [MSB_WIDTH-1:0]  msb_index;
        isqrt_case_e           special;
        logic [MANT_WIDTH-1:0] y;
    } nr_stage_t;

endpackage
